// File: Bender.yml
package:
  name: diversity_combiner

sources:
  - files:
      - hdl/combinerPkg.sv
      - hdl/combinerRegs.sv
      - hdl/agcDifferential.sv
      - hdl/combinerLockDetect.sv
      - hdl/combinerWeights.sv
      - hdl/diversityCombiner.sv
  - target: simulation
    files:
      - dv/combinerTb.sv

// File: build.f
hdl/combinerPkg.sv
hdl/combinerRegs.sv
hdl/agcDifferential.sv
hdl/combinerLockDetect.sv
hdl/combinerWeights.sv
hdl/diversityCombiner.sv
dv/combinerTb.sv

// File: dv/combinerGolden.txt
# W addr data byteEn | R cs addr expectedWord | L ch0Agc ch1Agc
# S ch0Sample ch1Sample realErr imagErr expectedSample lockBits(real imag locked), all hex
R 1 00 10000000
R 1 01 FF000000
R 1 05 03AA1800
R 1 06 00000000
W 00 FFFFFFFF F
W 00 00000000 2
R 1 00 13FF00FF
W 01 AABBCCDD D
R 1 01 FFBB00DD
R 0 05 00000000
R 1 3F 00000000
W 04 00010055 5
R 1 04 00010055
R 1 01 80BB00DD
W 05 01001800 C
L 1050 1000
R 1 06 00000050
R 1 01 D0BB00DD
L 1000 1050
R 1 00 0BFF00FF
R 1 01 30BB00DD
W 05 01551800 C
R 1 01 15BB00DD
W 05 02001800 C
R 1 00 1BFF00FF
L 4000 1000
R 1 06 00001800
L 1000 4000
R 1 06 0000E800
W 05 0000FFFF 3
L FFFF 0000
R 1 06 00007FFF
L 0000 FFFF
R 1 06 00008000
W 06 F0000000 C
L 1000 1000
R 1 06 F0001000
W 06 00000000 C
W 05 01001800 F
L 1010 1000
R 1 01 90BB00DD
W 04 00000000 4
R 1 01 FFBB00DD
L 1000 1010
R 1 00 1BFF00FF
W 04 00010000 4
W 03 00020010 F
R 1 03 00020010
L 1040 1000
R 1 01 C0BB00DD
S 0100 0200 0005 FFF8 0140 0
S FF00 0100 0002 000F FF80 7
S 0003 FFFD FFF1 0010 0001 4
S FFFD 0003 0000 0000 FFFE 4
S 1234 0000 0020 0000 0DA7 2

// File: dv/combinerTb.sv
// Run from the project root so the golden file path resolves; sampleWidth stays 16 to match its records.
`timescale 1ns/1ps
`default_nettype none

module combinerTb;

    import combinerPkg::*;

    localparam int sampleWidth = 16;
    localparam int blendTimeout = 20;

    logic                          busClk;
    logic                          rstN;
    logic                          cs;
    logic [regAddrWidth-1:0]       addr;
    logic [busWidth-1:0]           writeData;
    logic [laneCount-1:0]          byteEn;
    logic [agcWidth-1:0]           ch0Agc;
    logic [agcWidth-1:0]           ch1Agc;
    logic                          sampleValid;
    logic signed [sampleWidth-1:0] ch0Sample;
    logic signed [sampleWidth-1:0] ch1Sample;
    logic signed [sampleWidth-1:0] realErr;
    logic signed [sampleWidth-1:0] imagErr;
    logic [busWidth-1:0]           readData;
    logic [25:0]                   lagCoef;
    logic [23:0]                   leadCoef;
    logic [31:0]                   sweepRate;
    logic [15:0]                   sweepLimit;
    logic                          combinedValid;
    logic signed [sampleWidth-1:0] combinedSample;

    int wordErrors = 0;
    int sampleErrors = 0;
    int lockErrors = 0;
    int otherErrors = 0;
    int cycle = 0;
    int fd;

    // expected blend results and the cycle each one is due, oldest first.
    logic signed [sampleWidth-1:0] expSamples[$];
    int                            dueCycles[$];

    diversityCombiner #(.sampleWidth(sampleWidth)) uut (
        .busClk(busClk), .rstN(rstN), .cs(cs), .addr(addr), .writeData(writeData),
        .byteEn(byteEn), .ch0Agc(ch0Agc), .ch1Agc(ch1Agc), .sampleValid(sampleValid),
        .ch0Sample(ch0Sample), .ch1Sample(ch1Sample), .realErr(realErr), .imagErr(imagErr),
        .readData(readData), .lagCoef(lagCoef), .leadCoef(leadCoef), .sweepRate(sweepRate),
        .sweepLimit(sweepLimit), .combinedValid(combinedValid), .combinedSample(combinedSample)
    );

    initial begin
        busClk = 1'b0;
        forever #2 busClk = ~busClk;
    end

    always @(posedge busClk) begin
        cycle <= cycle + 1;
    end

    task checkWord(input string name, input logic [busWidth-1:0] expected,
                   input logic [busWidth-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, expected, actual);
            wordErrors++;
        end
    endtask

    task checkSample(input string name, input logic signed [sampleWidth-1:0] expected,
                     input logic signed [sampleWidth-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns %s expected %h actual %h", $time, name, expected, actual);
            sampleErrors++;
        end
    endtask

    task checkLock(input string name, input logic [2:0] expected, input logic [2:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns %s expected %b actual %b", $time, name, expected, actual);
            lockErrors++;
        end
    endtask

    // the exported coefficient of a word must match the stored bits of its read-back.
    task compareExport(input logic [regAddrWidth-1:0] eAddr,
                       input logic [busWidth-1:0] expected);
        case (eAddr)
            addrLagCoef: begin
                checkWord("lagCoef", {6'b0, expected[25:0]}, {6'b0, lagCoef});
            end
            addrLeadCoef: begin
                checkWord("leadCoef", {8'b0, expected[23:0]}, {8'b0, leadCoef});
            end
            addrSweepRate: begin
                checkWord("sweepRate", expected, sweepRate);
            end
            addrSweepOptions: begin
                checkWord("sweepLimit", {16'b0, expected[15:0]}, {16'b0, sweepLimit});
            end
            default: ;
        endcase
    endtask

    // outputs are taken on the falling edge, half a cycle away from any register update.
    always @(negedge busClk) begin
        if (combinedValid === 1'b1) begin
            if (expSamples.size() == 0) begin
                $display("combinedValid rose at %0d ns with no sample in flight", $time);
                otherErrors++;
            end else begin
                if (dueCycles[0] != cycle) begin
                    $display("blended sample came in cycle %0d but was due in cycle %0d",
                             cycle, dueCycles[0]);
                    otherErrors++;
                end
                checkSample("combinedSample", expSamples[0], combinedSample);
                void'(expSamples.pop_front());
                void'(dueCycles.pop_front());
            end
        end
    end

    task writeWord(input logic [regAddrWidth-1:0] wAddr, input logic [busWidth-1:0] wData,
                   input logic [laneCount-1:0] wEn);
        sampleValid = 1'b0;
        cs = 1'b1;
        addr = wAddr;
        writeData = wData;
        byteEn = wEn;
        @(negedge busClk);
        cs = 1'b0;
        byteEn = '0;
        // differential and then index follow a new setting one cycle apart.
        repeat (2) @(negedge busClk);
    endtask

    task readWord(input logic rCs, input logic [regAddrWidth-1:0] rAddr,
                  input logic [busWidth-1:0] expected);
        sampleValid = 1'b0;
        cs = rCs;
        addr = rAddr;
        byteEn = '0;
        #1;
        checkWord("readData", expected, readData);
        if (rCs) begin
            compareExport(rAddr, expected);
        end
        @(negedge busClk);
        cs = 1'b0;
    endtask

    task setLevels(input logic [agcWidth-1:0] level0, input logic [agcWidth-1:0] level1);
        sampleValid = 1'b0;
        cs = 1'b0;
        ch0Agc = level0;
        ch1Agc = level1;
        repeat (2) @(negedge busClk);
    endtask

    // the lag word stays addressed so the lock bits can be read one cycle later.
    task sendSample(input logic signed [sampleWidth-1:0] s0,
                    input logic signed [sampleWidth-1:0] s1,
                    input logic signed [sampleWidth-1:0] e0,
                    input logic signed [sampleWidth-1:0] e1,
                    input logic signed [sampleWidth-1:0] expSample, input logic [2:0] expLock);
        cs = 1'b1;
        addr = addrLagCoef;
        byteEn = '0;
        ch0Sample = s0;
        ch1Sample = s1;
        realErr = e0;
        imagErr = e1;
        sampleValid = 1'b1;
        expSamples.push_back(expSample);
        dueCycles.push_back(cycle + 2);
        @(negedge busClk);
        checkLock("realLock/imagLock/locked", expLock, readData[31:29]);
    endtask

    task drainBlend();
        int waited;
        sampleValid = 1'b0;
        cs = 1'b0;
        waited = 0;
        while (expSamples.size() != 0 && waited < blendTimeout) begin
            @(negedge busClk);
            waited++;
        end
        if (expSamples.size() != 0) begin
            $display("timed out with %0d blended samples never shown on combinedValid",
                     expSamples.size());
            otherErrors++;
        end
    endtask

    task runGolden();
        logic [7:0]                    kind;
        logic [8*160-1:0]              skipLine;
        logic                          recCs;
        logic [regAddrWidth-1:0]       recAddr;
        logic [busWidth-1:0]           recData;
        logic [laneCount-1:0]          recEn;
        logic [agcWidth-1:0]           recAgc0;
        logic [agcWidth-1:0]           recAgc1;
        logic signed [sampleWidth-1:0] recS0;
        logic signed [sampleWidth-1:0] recS1;
        logic signed [sampleWidth-1:0] recE0;
        logic signed [sampleWidth-1:0] recE1;
        logic signed [sampleWidth-1:0] recExp;
        logic [2:0]                    recLock;
        int                            code;
        while ($fscanf(fd, " %c", kind) == 1) begin
            code = 0;
            case (kind)
                "#": void'($fgets(skipLine, fd));
                "W": begin
                    code = $fscanf(fd, "%h %h %h", recAddr, recData, recEn) - 3;
                    writeWord(recAddr, recData, recEn);
                end
                "R": begin
                    code = $fscanf(fd, "%h %h %h", recCs, recAddr, recData) - 3;
                    readWord(recCs, recAddr, recData);
                end
                "L": begin
                    code = $fscanf(fd, "%h %h", recAgc0, recAgc1) - 2;
                    setLevels(recAgc0, recAgc1);
                end
                "S": begin
                    code = $fscanf(fd, "%h %h %h %h %h %h", recS0, recS1, recE0, recE1,
                                   recExp, recLock) - 6;
                    sendSample(recS0, recS1, recE0, recE1, recExp, recLock);
                end
                default: begin
                    $display("the golden file holds an unknown record kind '%c'", kind);
                    otherErrors++;
                end
            endcase
            if (code != 0) begin
                $display("a '%c' record in the golden file is missing fields", kind);
                otherErrors++;
            end
        end
    endtask

    initial begin
        rstN = 1'b0;
        cs = 1'b0;
        addr = '0;
        writeData = '0;
        byteEn = '0;
        ch0Agc = '0;
        ch1Agc = '0;
        sampleValid = 1'b0;
        ch0Sample = '0;
        ch1Sample = '0;
        realErr = '0;
        imagErr = '0;
        repeat (3) @(negedge busClk);
        rstN = 1'b1;
        @(negedge busClk);
        // every exported coefficient leaves reset at zero.
        checkWord("lagCoef", '0, {6'b0, lagCoef});
        checkWord("leadCoef", '0, {8'b0, leadCoef});
        checkWord("sweepRate", '0, sweepRate);
        checkWord("sweepLimit", '0, {16'b0, sweepLimit});
        fd = $fopen("dv/combinerGolden.txt", "r");
        if (fd == 0) begin
            $display("could not open dv/combinerGolden.txt, so no stimulus was applied");
            otherErrors++;
        end else begin
            runGolden();
            $fclose(fd);
        end
        drainBlend();
        repeat (4) @(negedge busClk);
        $display("errors: word %0d, sample %0d, lock %0d, other %0d",
                 wordErrors, sampleErrors, lockErrors, otherErrors);
        if (wordErrors + sampleErrors + lockErrors + otherErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/agcDifferential.sv
// AGC differential with a signed zero offset and an unsigned clip range; output lags the inputs by one cycle.
`timescale 1ns/1ps
`default_nettype none

module agcDifferential (
    input  logic                                    busClk,
    input  logic                                    rstN,
    input  logic [combinerPkg::agcWidth-1:0]        ch0Agc,
    input  logic [combinerPkg::agcWidth-1:0]        ch1Agc,
    input  logic signed [combinerPkg::agcWidth-1:0] agcZero,
    input  logic [combinerPkg::agcWidth-1:0]        dbRange,
    output logic signed [combinerPkg::agcWidth-1:0] differential,
    output logic                                    ch1IsMaster
);

    import combinerPkg::*;

    // two extra bits hold the full difference of two unsigned levels and a signed offset.
    localparam int wideWidth = agcWidth + 2;

    localparam logic signed [wideWidth-1:0] satHigh = (1 <<< (agcWidth - 1)) - 1;
    localparam logic signed [wideWidth-1:0] satLow  = -(1 <<< (agcWidth - 1));

    logic signed [wideWidth-1:0] rawDiff;
    logic signed [wideWidth-1:0] satDiff;
    logic signed [wideWidth-1:0] rangeWide;
    logic signed [wideWidth-1:0] clipDiff;

    always_comb begin
        rawDiff   = $signed({2'b0, ch0Agc}) - $signed({2'b0, ch1Agc}) - agcZero;
        rangeWide = $signed({2'b0, dbRange});

        if (rawDiff > satHigh) begin
            satDiff = satHigh;
        end else if (rawDiff < satLow) begin
            satDiff = satLow;
        end else begin
            satDiff = rawDiff;
        end

        // a range above full scale never clips.
        if (satDiff > rangeWide) begin
            clipDiff = rangeWide;
        end else if (satDiff < -rangeWide) begin
            clipDiff = -rangeWide;
        end else begin
            clipDiff = satDiff;
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            differential <= '0;
            ch1IsMaster  <= 1'b0;
        end else begin
            differential <= clipDiff[agcWidth-1:0];
            ch1IsMaster  <= clipDiff[wideWidth-1];
        end
    end

endmodule : agcDifferential

`default_nettype wire

// File: hdl/combinerLockDetect.sv
// Phase-error lock detector; counters and flags only move on sampleValid, and run counts saturate at 16 bits.
`timescale 1ns/1ps
`default_nettype none

module combinerLockDetect #(
    parameter int sampleWidth = 16
) (
    input  logic                          busClk,
    input  logic                          rstN,
    input  logic                          sampleValid,
    input  logic signed [sampleWidth-1:0] realErr,
    input  logic signed [sampleWidth-1:0] imagErr,
    input  logic [15:0]                   lockThreshold,
    input  logic [15:0]                   lockCount,
    output logic                          realLock,
    output logic                          imagLock,
    output logic                          locked
);

    // arm 0 is the real arm, arm 1 the imaginary arm.
    localparam int armCount = 2;

    logic signed [sampleWidth-1:0] armErr    [armCount];
    logic [sampleWidth-1:0]        absErr    [armCount];
    logic                          armSmall  [armCount];
    logic [15:0]                   runCount  [armCount];
    logic [15:0]                   nextCount [armCount];
    logic [armCount-1:0]           armLock;

    assign armErr[0] = realErr;
    assign armErr[1] = imagErr;

    always_comb begin
        for (int arm = 0; arm < armCount; arm++) begin
            // the most negative error maps to its true magnitude as an unsigned value.
            absErr[arm]   = armErr[arm][sampleWidth-1] ? -armErr[arm] : armErr[arm];
            armSmall[arm] = absErr[arm] < lockThreshold;

            if (!armSmall[arm]) begin
                nextCount[arm] = '0;
            end else if (runCount[arm] == 16'hFFFF) begin
                nextCount[arm] = runCount[arm];
            end else begin
                nextCount[arm] = runCount[arm] + 16'd1;
            end
        end
    end

    // a large error drops the flag at once, even when lockCount is zero.
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            for (int arm = 0; arm < armCount; arm++) begin
                runCount[arm] <= '0;
            end
            armLock <= '0;
        end else if (sampleValid) begin
            for (int arm = 0; arm < armCount; arm++) begin
                runCount[arm] <= nextCount[arm];
                armLock[arm]  <= armSmall[arm] && (nextCount[arm] >= lockCount);
            end
        end
    end

    assign realLock = armLock[0];
    assign imagLock = armLock[1];
    assign locked   = &armLock;

endmodule : combinerLockDetect

`default_nettype wire

// File: hdl/combinerPkg.sv
// Shared widths and register word addresses; each register word has exactly one address.
`default_nettype none

package combinerPkg;

    // host bus data width in bits.
    localparam int busWidth = 32;

    // the host addresses 32-bit words, not bytes.
    localparam int regAddrWidth = 6;

    // AGC levels are unsigned, in units of 1/256 dB.
    localparam int agcWidth = 16;

    // the weight index runs from 0 (all channel 1) to 255 (almost all channel 0).
    localparam int indexWidth = 8;

    // number of byte lanes on the host bus.
    localparam int laneCount = busWidth / 8;

    // register word addresses.
    localparam logic [regAddrWidth-1:0] addrLagCoef      = 6'd0;
    localparam logic [regAddrWidth-1:0] addrLeadCoef     = 6'd1;
    localparam logic [regAddrWidth-1:0] addrSweepRate    = 6'd2;
    localparam logic [regAddrWidth-1:0] addrLocks        = 6'd3;

    // sweep limit in the low half, option bits in the high half.
    localparam logic [regAddrWidth-1:0] addrSweepOptions = 6'd4;

    // dB range in the low half, dB ratio in the high half.
    localparam logic [regAddrWidth-1:0] addrDbRangeRatio = 6'd5;

    // the differential (read only) sits in the low half, the AGC zero in the high half.
    localparam logic [regAddrWidth-1:0] addrAgcZeroDiff  = 6'd6;

    // the range resets to 24 dB.
    localparam logic [15:0] dbRangeReset = 16'h1800;

    // the ratio is unsigned Q8.8.
    localparam logic [15:0] dbRatioReset = 16'h03AA;

endpackage : combinerPkg

`default_nettype wire

// File: hdl/combinerRegs.sv
// Host setup registers; lag bit 26 is reserved and reads zero, lead lane 3 and AGC word low lanes are ignored.
`timescale 1ns/1ps
`default_nettype none

module combinerRegs (
    input  logic                                   busClk,
    input  logic                                   rstN,
    input  logic                                   cs,
    input  logic [combinerPkg::regAddrWidth-1:0]   addr,
    input  logic [combinerPkg::busWidth-1:0]       writeData,
    input  logic [combinerPkg::laneCount-1:0]      byteEn,
    input  logic signed [combinerPkg::agcWidth-1:0] differential,
    input  logic                                   ch1IsMaster,
    input  logic                                   realLock,
    input  logic                                   imagLock,
    input  logic                                   locked,
    input  logic [combinerPkg::indexWidth-1:0]     weightIndex,
    input  logic                                   indexAtRail,
    output logic [combinerPkg::busWidth-1:0]       readData,
    output logic [25:0]                            lagCoef,
    output logic [23:0]                            leadCoef,
    output logic [31:0]                            sweepRate,
    output logic [15:0]                            sweepLimit,
    output logic [15:0]                            lockThreshold,
    output logic [15:0]                            lockCount,
    output logic                                   combineEnable,
    output logic [15:0]                            agcZero,
    output logic [15:0]                            dbRange,
    output logic [15:0]                            dbRatio
);

    import combinerPkg::*;

    // only bit 0 is used by hardware, the rest are kept for software.
    logic [15:0]         optionBits;
    logic [busWidth-1:0] storedWord;
    logic [busWidth-1:0] mergedWord;

    // replaces the enabled byte lanes of a word with the bus data.
    function automatic logic [busWidth-1:0] mergeLanes(
        input logic [busWidth-1:0]  oldWord,
        input logic [busWidth-1:0]  newWord,
        input logic [laneCount-1:0] laneEn
    );
        logic [busWidth-1:0] result;
        result = oldWord;
        for (int lane = 0; lane < laneCount; lane++) begin
            if (laneEn[lane]) begin
                result[8*lane +: 8] = newWord[8*lane +: 8];
            end
        end
        return result;
    endfunction

    // stored contents of the addressed word, before any write.
    always_comb begin
        case (addr)
            addrLagCoef:      storedWord = {6'b0, lagCoef};
            addrLeadCoef:     storedWord = {8'b0, leadCoef};
            addrSweepRate:    storedWord = sweepRate;
            addrLocks:        storedWord = {lockCount, lockThreshold};
            addrSweepOptions: storedWord = {optionBits, sweepLimit};
            addrDbRangeRatio: storedWord = {dbRatio, dbRange};
            addrAgcZeroDiff:  storedWord = {agcZero, 16'b0};
            default:          storedWord = '0;
        endcase
    end

    assign mergedWord = mergeLanes(storedWord, writeData, byteEn);

    // each field takes only its own bits of the merged word, so lanes outside it are dropped.
    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            lagCoef       <= '0;
            leadCoef      <= '0;
            sweepRate     <= '0;
            lockThreshold <= '0;
            lockCount     <= '0;
            sweepLimit    <= '0;
            optionBits    <= '0;
            dbRange       <= dbRangeReset;
            dbRatio       <= dbRatioReset;
            agcZero       <= '0;
        end else if (cs) begin
            case (addr)
                addrLagCoef:      lagCoef <= mergedWord[25:0];
                addrLeadCoef:     leadCoef <= mergedWord[23:0];
                addrSweepRate:    sweepRate <= mergedWord;
                addrLocks: begin
                    lockThreshold <= mergedWord[15:0];
                    lockCount     <= mergedWord[31:16];
                end
                addrSweepOptions: begin
                    sweepLimit <= mergedWord[15:0];
                    optionBits <= mergedWord[31:16];
                end
                addrDbRangeRatio: begin
                    dbRange <= mergedWord[15:0];
                    dbRatio <= mergedWord[31:16];
                end
                addrAgcZeroDiff:  agcZero <= mergedWord[31:16];
                default: ;
            endcase
        end
    end

    assign combineEnable = optionBits[0];

    // live status rides in the upper bits of the lag and lead words.
    always_comb begin
        readData = '0;
        if (cs) begin
            case (addr)
                addrLagCoef: readData = {realLock, imagLock, locked, indexAtRail,
                                         ch1IsMaster, 1'b0, lagCoef};
                addrLeadCoef:     readData = {weightIndex, leadCoef};
                addrSweepRate:    readData = sweepRate;
                addrLocks:        readData = {lockCount, lockThreshold};
                addrSweepOptions: readData = {optionBits, sweepLimit};
                addrDbRangeRatio: readData = {dbRatio, dbRange};
                addrAgcZeroDiff:  readData = {agcZero, differential};
                default:          readData = '0;
            endcase
        end
    end

endmodule : combinerRegs

`default_nettype wire

// File: hdl/combinerWeights.sv
// Weight index and blend; the index lags the differential by one cycle, the blend takes two cycles with no stall.
`timescale 1ns/1ps
`default_nettype none

module combinerWeights #(
    parameter int sampleWidth = 16
) (
    input  logic                                    busClk,
    input  logic                                    rstN,
    input  logic signed [combinerPkg::agcWidth-1:0] differential,
    input  logic                                    ch1IsMaster,
    input  logic [15:0]                             dbRatio,
    input  logic                                    combineEnable,
    input  logic                                    sampleValid,
    input  logic signed [sampleWidth-1:0]           ch0Sample,
    input  logic signed [sampleWidth-1:0]           ch1Sample,
    output logic [combinerPkg::indexWidth-1:0]      weightIndex,
    output logic                                    indexAtRail,
    output logic                                    combinedValid,
    output logic signed [sampleWidth-1:0]           combinedSample
);

    import combinerPkg::*;

    // signed differential times a 17-bit non-negative ratio.
    localparam int prodWidth  = agcWidth + 17;
    localparam int blendWidth = sampleWidth + indexWidth + 2;
    localparam logic [indexWidth-1:0] indexMax = '1;

    logic signed [prodWidth-1:0]  scaled;
    logic signed [prodWidth-1:0]  biased;
    logic [indexWidth-1:0]        nextIndex;
    logic [indexWidth:0]          weightComp;
    logic signed [blendWidth-1:0] prod0;
    logic signed [blendWidth-1:0] prod1;
    logic signed [blendWidth-1:0] blendSum;
    logic                         stage1Valid;

    always_comb begin
        scaled = differential * $signed({1'b0, dbRatio});
        biased = (scaled >>> 8) + (prodWidth)'(signed'(128));

        if (!combineEnable) begin
            // with combining off the master channel takes the whole output.
            nextIndex = ch1IsMaster ? '0 : indexMax;
        end else if (biased < 0) begin
            nextIndex = '0;
        end else if (biased > $signed({1'b0, indexMax})) begin
            nextIndex = indexMax;
        end else begin
            nextIndex = biased[indexWidth-1:0];
        end
    end

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            weightIndex <= '0;
        end else begin
            weightIndex <= nextIndex;
        end
    end

    assign indexAtRail = (weightIndex == '0) || (weightIndex == indexMax);

    // channel 1 weight is the remainder of 256.
    assign weightComp = {1'b1, {indexWidth{1'b0}}} - {1'b0, weightIndex};

    always_ff @(posedge busClk) begin
        if (sampleValid) begin
            prod0 <= ch0Sample * $signed({2'b0, weightIndex});
            prod1 <= ch1Sample * $signed({1'b0, weightComp});
        end
        if (stage1Valid) begin
            combinedSample <= blendSum[sampleWidth+7:8];
        end
    end

    assign blendSum = prod0 + prod1;

    always_ff @(posedge busClk or negedge rstN) begin
        if (!rstN) begin
            stage1Valid   <= 1'b0;
            combinedValid <= 1'b0;
        end else begin
            stage1Valid   <= sampleValid;
            combinedValid <= stage1Valid;
        end
    end

endmodule : combinerWeights

`default_nettype wire

// File: hdl/diversityCombiner.sv
// Two-channel combiner core; loop filter, sweep and DDS link are outside, their coefficients are only exported.
`timescale 1ns/1ps
`default_nettype none

module diversityCombiner #(
    parameter int sampleWidth = 16
) (
    input  logic                                 busClk,
    input  logic                                 rstN,
    input  logic                                 cs,
    input  logic [combinerPkg::regAddrWidth-1:0] addr,
    input  logic [combinerPkg::busWidth-1:0]     writeData,
    input  logic [combinerPkg::laneCount-1:0]    byteEn,
    input  logic [combinerPkg::agcWidth-1:0]     ch0Agc,
    input  logic [combinerPkg::agcWidth-1:0]     ch1Agc,
    input  logic                                 sampleValid,
    input  logic signed [sampleWidth-1:0]        ch0Sample,
    input  logic signed [sampleWidth-1:0]        ch1Sample,
    input  logic signed [sampleWidth-1:0]        realErr,
    input  logic signed [sampleWidth-1:0]        imagErr,
    output logic [combinerPkg::busWidth-1:0]     readData,
    output logic [25:0]                          lagCoef,
    output logic [23:0]                          leadCoef,
    output logic [31:0]                          sweepRate,
    output logic [15:0]                          sweepLimit,
    output logic                                 combinedValid,
    output logic signed [sampleWidth-1:0]        combinedSample
);

    import combinerPkg::*;

    logic [15:0]                  lockThreshold;
    logic [15:0]                  lockCount;
    logic                         combineEnable;
    logic signed [agcWidth-1:0]   agcZero;
    logic [agcWidth-1:0]          dbRange;
    logic [15:0]                  dbRatio;
    logic signed [agcWidth-1:0]   differential;
    logic                         ch1IsMaster;
    logic                         realLock;
    logic                         imagLock;
    logic                         locked;
    logic [indexWidth-1:0]        weightIndex;
    logic                         indexAtRail;

    combinerRegs regs (.*);

    agcDifferential agcDiff (.*);

    combinerLockDetect #(.sampleWidth(sampleWidth)) lockDetect (.*);

    combinerWeights #(.sampleWidth(sampleWidth)) weights (.*);

endmodule : diversityCombiner

`default_nettype wire
